//--- alu.sv
`timescale 1ns/1ns

module alu (
    input  riscv_pkg::alu_op_e         op_i,
    input  logic [riscv_pkg::XLEN-1:0] a_i,
    input  logic [riscv_pkg::XLEN-1:0] b_i,
    output logic [riscv_pkg::XLEN-1:0] y_o
);
    import riscv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ADD:    y_o = a_i + b_i;
            SUB:    y_o = a_i - b_i;
            SLL:    y_o = a_i << shamt;
            SLT:    y_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            SLTU:   y_o = {{(XLEN-1){1'b0}}, a_i < b_i};
            XOR:    y_o = a_i ^ b_i;
            SRL:    y_o = a_i >> shamt;
            SRA:    y_o = $signed(a_i) >>> shamt; // sign fill.
            OR:     y_o = a_i | b_i;
            AND:    y_o = a_i & b_i;
            PASS_B: y_o = b_i;
            default: y_o = '0;
        endcase
    end

endmodule

//--- core_de_top.sv
`timescale 1ns/1ns

module core_de_top #(
    parameter int NUM_REGS = 32
) (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         instr_valid_i,
    input  riscv_pkg::instr_t            instr_i,
    input  logic [riscv_pkg::XLEN-1:0]   pc_i,
    input  logic                         stall_i,
    input  logic                         flush_i,
    input  logic                         wb_en_i,
    input  logic [riscv_pkg::REG_AW-1:0] wb_addr_i,
    input  logic [riscv_pkg::XLEN-1:0]   wb_data_i,
    output riscv_pkg::ex_result_t        ex_o
);
    import riscv_pkg::*;

    de_bundle_t de_bundle; // decode output.
    de_bundle_t ex_bundle; // registered, feeds execute.

    decode_stage #(
        .NUM_REGS (NUM_REGS)
    ) u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .wb_en_i       (wb_en_i),
        .wb_addr_i     (wb_addr_i),
        .wb_data_i     (wb_data_i),
        .de_o          (de_bundle)
    );

    decode_exec_reg u_de_reg (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .de_i    (de_bundle),
        .ex_o    (ex_bundle)
    );

    exec_stage u_exec (
        .de_i (ex_bundle),
        .ex_o (ex_o)
    );

endmodule

//--- decode_exec_reg.sv
`timescale 1ns/1ns

module decode_exec_reg (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  riscv_pkg::de_bundle_t de_i,
    output riscv_pkg::de_bundle_t ex_o
);
    import riscv_pkg::*;

    de_bundle_t bubble;
    de_bundle_t de_q;

    // incoming bundle with valid and side effects cleared.
    always_comb begin
        bubble                = de_i;
        bubble.valid          = 1'b0;
        bubble.ctrl.reg_write = 1'b0;
        bubble.ctrl.mem_write = 1'b0;
        bubble.ctrl.branch    = 1'b0;
        bubble.ctrl.jal       = 1'b0;
        bubble.ctrl.jalr      = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            de_q <= '0;
        end else if (flush_i) begin
            de_q <= bubble; // wins over stall.
        end else if (!stall_i) begin
            de_q <= de_i;
        end
    end

    assign ex_o = de_q;

endmodule

//--- decode_stage.sv
`timescale 1ns/1ns

module decode_stage #(
    parameter int NUM_REGS = 32
) (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         instr_valid_i,
    input  riscv_pkg::instr_t            instr_i,
    input  logic [riscv_pkg::XLEN-1:0]   pc_i,
    input  logic                         wb_en_i,
    input  logic [riscv_pkg::REG_AW-1:0] wb_addr_i,
    input  logic [riscv_pkg::XLEN-1:0]   wb_data_i,
    output riscv_pkg::de_bundle_t        de_o
);
    import riscv_pkg::*;

    ctrl_t           ctrl;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    instr_decoder u_decoder (
        .instr_i (instr_i),
        .ctrl_o  (ctrl),
        .imm_o   (imm)
    );

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (instr_i.r_fmt.rs1),
        .rs2_addr_i (instr_i.r_fmt.rs2),
        .rd1_o      (rs1_data),
        .rd2_o      (rs2_data),
        .we_i       (wb_en_i),
        .wa_i       (wb_addr_i),
        .wd_i       (wb_data_i)
    );

    always_comb begin
        de_o.valid    = instr_valid_i;
        de_o.ctrl     = ctrl;
        de_o.pc       = pc_i;
        de_o.pc_plus4 = pc_i + XLEN'(4);
        de_o.rs1_data = rs1_data;
        de_o.rs2_data = rs2_data;
        de_o.src_b    = ctrl.src_b_imm ? imm : rs2_data; // operand b mux.
        de_o.imm      = imm;
        de_o.rd       = instr_i.r_fmt.rd; // same bits in every format with rd.
    end

endmodule

//--- exec_stage.sv
`timescale 1ns/1ns

module exec_stage (
    input  riscv_pkg::de_bundle_t de_i,
    output riscv_pkg::ex_result_t ex_o
);
    import riscv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] alu_y;
    logic [XLEN-1:0] jalr_sum;
    logic            cond;
    logic            taken;

    assign op_a = de_i.ctrl.src_a_pc ? de_i.pc : de_i.rs1_data;

    alu u_alu (
        .op_i (de_i.ctrl.alu_op),
        .a_i  (op_a),
        .b_i  (de_i.src_b),
        .y_o  (alu_y)
    );

    // branch compare, always on rs1 and rs2.
    always_comb begin
        case (de_i.ctrl.funct3)
            3'b000:  cond = (de_i.rs1_data == de_i.rs2_data);                   // beq.
            3'b001:  cond = (de_i.rs1_data != de_i.rs2_data);                   // bne.
            3'b100:  cond = ($signed(de_i.rs1_data) <  $signed(de_i.rs2_data)); // blt.
            3'b101:  cond = ($signed(de_i.rs1_data) >= $signed(de_i.rs2_data)); // bge.
            3'b110:  cond = (de_i.rs1_data <  de_i.rs2_data);                   // bltu.
            3'b111:  cond = (de_i.rs1_data >= de_i.rs2_data);                   // bgeu.
            default: cond = 1'b0;
        endcase
    end

    assign jalr_sum = de_i.rs1_data + de_i.imm;
    assign taken    = de_i.ctrl.jal | de_i.ctrl.jalr | (de_i.ctrl.branch & cond);

    always_comb begin
        ex_o.valid        = de_i.valid;
        ex_o.reg_write    = de_i.valid & de_i.ctrl.reg_write;
        ex_o.rd           = de_i.rd;
        ex_o.result       = de_i.ctrl.result_src ? de_i.pc_plus4 : alu_y;
        ex_o.mem_write    = de_i.valid & de_i.ctrl.mem_write;
        ex_o.store_addr   = alu_y; // rs1 + imm for stores.
        ex_o.store_data   = de_i.rs2_data;
        ex_o.branch_taken = de_i.valid & taken;
        // jalr target drops bit 0.
        ex_o.target       = de_i.ctrl.jalr ? {jalr_sum[XLEN-1:1], 1'b0}
                                           : de_i.pc + de_i.imm;
    end

endmodule

//--- golden_vectors.txt
// v stall flush wb_en wb_addr wb_data instr pc chk (1 result/rd, 2 store, 4 target)
// then expected ex_o: valid reg_write rd result mem_write store_addr store_data taken target
1 0 0 1 01 00000007 00208333 000000fc 1 1 1 06 00000000 0 00000000 00000000 0 00000000
0 0 0 1 02 fffffff0 00000000 00000000 0 0 0 00 00000000 0 00000000 00000000 0 00000000
0 0 0 1 03 00000003 00000000 00000000 0 0 0 00 00000000 0 00000000 00000000 0 00000000
1 0 0 1 04 80000000 00208333 00000100 1 1 1 06 fffffff7 0 00000000 00000000 0 00000000
1 0 0 1 05 00000007 402083b3 00000104 1 1 1 07 00000017 0 00000000 00000000 0 00000000
1 0 0 1 00 deadbeef 00309433 00000108 1 1 1 08 00000038 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 003154b3 0000010c 1 1 1 09 1ffffffe 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 40315533 00000110 1 1 1 0a fffffffe 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 001125b3 00000114 1 1 1 0b 00000001 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 00113633 00000118 1 1 1 0c 00000000 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 0020c6b3 0000011c 1 1 1 0d fffffff7 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 0030e733 00000120 1 1 1 0e 00000007 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 0030f7b3 00000124 1 1 1 0f 00000003 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 ffd08813 00000128 1 1 1 10 00000004 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 0080b913 0000012c 1 1 1 12 00000001 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 fff0c993 00000130 1 1 1 13 fffffff8 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 00409a13 00000134 1 1 1 14 00000070 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 40425a93 00000138 1 1 1 15 f8000000 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 00100c33 0000013c 1 1 1 18 00000007 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 12345cb7 00000200 1 1 1 19 12345000 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 00001d17 00000204 1 1 1 1a 00001204 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 ff9ffe6f 00000400 5 1 1 1c 00000404 0 00000000 00000000 1 000003f8
1 0 0 0 00 00000000 00608ee7 00000500 5 1 1 1d 00000504 0 00000000 00000000 1 0000000c
1 0 0 0 00 00000000 00508863 00000600 4 1 0 00 00000000 0 00000000 00000000 1 00000610
1 0 0 0 00 00000000 00308863 00000604 4 1 0 00 00000000 0 00000000 00000000 0 00000614
1 0 0 0 00 00000000 00309863 00000608 4 1 0 00 00000000 0 00000000 00000000 1 00000618
1 0 0 0 00 00000000 00509863 0000060c 4 1 0 00 00000000 0 00000000 00000000 0 0000061c
1 0 0 0 00 00000000 00114863 00000610 4 1 0 00 00000000 0 00000000 00000000 1 00000620
1 0 0 0 00 00000000 0020c863 00000614 4 1 0 00 00000000 0 00000000 00000000 0 00000624
1 0 0 0 00 00000000 0020d863 00000618 4 1 0 00 00000000 0 00000000 00000000 1 00000628
1 0 0 0 00 00000000 00115863 0000061c 4 1 0 00 00000000 0 00000000 00000000 0 0000062c
1 0 0 0 00 00000000 0020e863 00000620 4 1 0 00 00000000 0 00000000 00000000 1 00000630
1 0 0 0 00 00000000 00116863 00000624 4 1 0 00 00000000 0 00000000 00000000 0 00000634
1 0 0 0 00 00000000 00117863 00000628 4 1 0 00 00000000 0 00000000 00000000 1 00000638
1 0 0 0 00 00000000 0020f863 0000062c 4 1 0 00 00000000 0 00000000 00000000 0 0000063c
1 0 0 0 00 00000000 0020a423 00000800 2 1 0 00 00000000 1 0000000f fffffff0 0 00000000
1 1 0 1 06 00000100 402083b3 00000804 2 1 0 00 00000000 1 0000000f fffffff0 0 00000000
1 1 1 0 00 00000000 fe320e23 00000808 0 0 0 00 00000000 0 00000000 00000000 0 00000000
1 0 1 0 00 00000000 ff9ffe6f 00000400 0 0 0 00 00000000 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 00330f33 00000900 1 1 1 1e 00000103 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 fe320e23 00000904 2 1 0 00 00000000 1 7ffffffc 00000003 0 00000000
0 0 0 0 00 00000000 00208333 00000908 0 0 0 00 00000000 0 00000000 00000000 0 00000000
1 0 0 0 00 00000000 0000007f 0000090c 0 1 0 00 00000000 0 00000000 00000000 0 00000000

//--- instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
    input  riscv_pkg::instr_t          instr_i,
    output riscv_pkg::ctrl_t           ctrl_o,
    output logic [riscv_pkg::XLEN-1:0] imm_o
);
    import riscv_pkg::*;

    logic [6:0] opcode;
    logic       alt_bit; // instr bit 30.

    assign opcode  = instr_i.r_fmt.opcode;
    assign alt_bit = instr_i.r_fmt.funct7[5];

    // funct3 to alu op, alt picks sub or sra.
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: imm_o = {instr_i.u_fmt.imm_31_12, 12'b0};
            OPC_JAL: imm_o = {{(XLEN-21){instr_i.j_fmt.imm_20}}, instr_i.j_fmt.imm_20,
                              instr_i.j_fmt.imm_19_12, instr_i.j_fmt.imm_11,
                              instr_i.j_fmt.imm_10_1, 1'b0};
            OPC_JALR, OPC_OP_IMM: imm_o = {{(XLEN-12){instr_i.i_fmt.imm_11_0[11]}},
                                           instr_i.i_fmt.imm_11_0};
            OPC_BRANCH: imm_o = {{(XLEN-13){instr_i.b_fmt.imm_12}}, instr_i.b_fmt.imm_12,
                                 instr_i.b_fmt.imm_11, instr_i.b_fmt.imm_10_5,
                                 instr_i.b_fmt.imm_4_1, 1'b0};
            OPC_STORE: imm_o = {{(XLEN-12){instr_i.s_fmt.imm_11_5[6]}},
                                instr_i.s_fmt.imm_11_5, instr_i.s_fmt.imm_4_0};
            default: imm_o = '0;
        endcase
    end

    always_comb begin
        ctrl_o = '0; // unknown opcode is a no-op.
        case (opcode)
            OPC_LUI: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_op    = PASS_B;
                ctrl_o.src_b_imm = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_op    = ADD;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.src_a_pc  = 1'b1;
            end
            OPC_JAL: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.result_src = 1'b1;
                ctrl_o.jal        = 1'b1;
            end
            OPC_JALR: begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.result_src = 1'b1;
                ctrl_o.src_b_imm  = 1'b1;
                ctrl_o.jalr       = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl_o.branch = 1'b1;
                ctrl_o.funct3 = instr_i.b_fmt.funct3; // selects the compare.
            end
            OPC_STORE: begin
                ctrl_o.mem_write = 1'b1;
                ctrl_o.alu_op    = ADD;
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.funct3    = instr_i.s_fmt.funct3;
            end
            OPC_OP_IMM: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.src_b_imm = 1'b1;
                // only srai uses bit 30, addi has no subtract.
                ctrl_o.alu_op = arith_op(instr_i.i_fmt.funct3,
                                         alt_bit && (instr_i.i_fmt.funct3 == 3'b101));
            end
            OPC_OP: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_op    = arith_op(instr_i.r_fmt.funct3, alt_bit);
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

//--- reg_file.sv
`timescale 1ns/1ns

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic [riscv_pkg::REG_AW-1:0] rs1_addr_i,
    input  logic [riscv_pkg::REG_AW-1:0] rs2_addr_i,
    output logic [riscv_pkg::XLEN-1:0]   rd1_o,
    output logic [riscv_pkg::XLEN-1:0]   rd2_o,
    input  logic                         we_i,
    input  logic [riscv_pkg::REG_AW-1:0] wa_i,
    input  logic [riscv_pkg::XLEN-1:0]   wd_i
);
    import riscv_pkg::*;

    logic [XLEN-1:0] regs_q [1:NUM_REGS-1]; // x0 not stored.

    function automatic logic in_range(input logic [REG_AW-1:0] idx);
        return (idx != '0) && (int'(idx) < NUM_REGS);
    endfunction

    // no write-through.
    assign rd1_o = in_range(rs1_addr_i) ? regs_q[rs1_addr_i] : '0;
    assign rd2_o = in_range(rs2_addr_i) ? regs_q[rs2_addr_i] : '0;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && in_range(wa_i)) begin
            regs_q[wa_i] <= wd_i;
        end
    end

endmodule

//--- riscv_pkg.sv
package riscv_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // base opcodes handled by the slice.
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10 // lui.
    } alu_op_e;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]       imm_11_0;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]        imm_11_5;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [4:0]        imm_4_0;
        logic [6:0]        opcode;
    } s_fmt_t;

    typedef struct packed {
        logic              imm_12;
        logic [5:0]        imm_10_5;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [3:0]        imm_4_1;
        logic              imm_11;
        logic [6:0]        opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]       imm_31_12;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } u_fmt_t;

    typedef struct packed {
        logic              imm_20;
        logic [9:0]        imm_10_1;
        logic              imm_11;
        logic [7:0]        imm_19_12;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } j_fmt_t;

    // one instruction word, six decodings.
    typedef union packed {
        logic [XLEN-1:0] raw;
        r_fmt_t          r_fmt;
        i_fmt_t          i_fmt;
        s_fmt_t          s_fmt;
        b_fmt_t          b_fmt;
        u_fmt_t          u_fmt;
        j_fmt_t          j_fmt;
    } instr_t;

    typedef struct packed {
        logic       reg_write;
        logic       mem_write;
        logic       result_src; // 0 alu, 1 pc+4.
        alu_op_e    alu_op;
        logic       src_b_imm;
        logic       src_a_pc;   // auipc.
        logic       branch;
        logic       jal;
        logic       jalr;
        logic [2:0] funct3;
    } ctrl_t;

    typedef struct packed {
        logic              valid;
        ctrl_t             ctrl;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   pc_plus4;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [XLEN-1:0]   src_b;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] rd;
    } de_bundle_t;

    typedef struct packed {
        logic              valid;
        logic              reg_write;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   result;
        logic              mem_write;
        logic [XLEN-1:0]   store_addr;
        logic [XLEN-1:0]   store_data;
        logic              branch_taken;
        logic [XLEN-1:0]   target;
    } ex_result_t;

endpackage

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -f src.f --top-module tb_core_de -o sim_core_de
./obj_dir/sim_core_de > sim.log 2>&1 || true
cat sim.log
if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

//--- src.f
riscv_pkg.sv
instr_decoder.sv
reg_file.sv
decode_stage.sv
decode_exec_reg.sv
alu.sv
exec_stage.sv
core_de_top.sv
tb_core_de.sv

//--- tb_core_de.sv
`timescale 1ns/1ns

module tb_core_de;
    import riscv_pkg::*;

    localparam int NUM_VEC   = 43;
    localparam int VEC_WORDS = 18; // tokens per line of the vector file.
    localparam int RST_LIMIT = 16;

    typedef struct packed {
        logic              instr_valid;
        logic              stall;
        logic              flush;
        logic              wb_en;
        logic [REG_AW-1:0] wb_addr;
        logic [XLEN-1:0]   wb_data;
        logic [XLEN-1:0]   instr;
        logic [XLEN-1:0]   pc;
        logic [3:0]        chk; // 1 result and rd, 2 store, 4 target.
        ex_result_t        exp;
    } vec_t;

    logic              clk = 1'b0;
    logic              rst_n_i;
    logic              instr_valid_i;
    instr_t            instr_i;
    logic [XLEN-1:0]   pc_i;
    logic              stall_i;
    logic              flush_i;
    logic              wb_en_i;
    logic [REG_AW-1:0] wb_addr_i;
    logic [XLEN-1:0]   wb_data_i;
    ex_result_t        ex_o;

    logic [31:0] words [0:NUM_VEC*VEC_WORDS-1];
    vec_t        vecs  [0:NUM_VEC-1];

    core_de_top #(
        .NUM_REGS (32)
    ) DUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .wb_en_i       (wb_en_i),
        .wb_addr_i     (wb_addr_i),
        .wb_data_i     (wb_data_i),
        .ex_o          (ex_o)
    );

    always #2 clk = ~clk;

    initial begin
        rst_n_i = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
    end

    function automatic vec_t unpack_vec(input int base);
        vec_t v;
        v.instr_valid      = words[base][0];
        v.stall            = words[base+1][0];
        v.flush            = words[base+2][0];
        v.wb_en            = words[base+3][0];
        v.wb_addr          = words[base+4][REG_AW-1:0];
        v.wb_data          = words[base+5];
        v.instr            = words[base+6];
        v.pc               = words[base+7];
        v.chk              = words[base+8][3:0];
        v.exp.valid        = words[base+9][0];
        v.exp.reg_write    = words[base+10][0];
        v.exp.rd           = words[base+11][REG_AW-1:0];
        v.exp.result       = words[base+12];
        v.exp.mem_write    = words[base+13][0];
        v.exp.store_addr   = words[base+14];
        v.exp.store_data   = words[base+15];
        v.exp.branch_taken = words[base+16][0];
        v.exp.target       = words[base+17];
        return v;
    endfunction

    task automatic drive_vec(input vec_t v);
        instr_valid_i = v.instr_valid;
        instr_i.raw   = v.instr;
        pc_i          = v.pc;
        stall_i       = v.stall;
        flush_i       = v.flush;
        wb_en_i       = v.wb_en;
        wb_addr_i     = v.wb_addr;
        wb_data_i     = v.wb_data;
    endtask

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // checks flags always and data fields where chk asks.
    task automatic compare_ex(input string tag, input ex_result_t exp, input logic [3:0] chk);
        check_val({"ex_o.valid ", tag}, 32'(ex_o.valid), 32'(exp.valid));
        check_val({"ex_o.reg_write ", tag}, 32'(ex_o.reg_write), 32'(exp.reg_write));
        check_val({"ex_o.mem_write ", tag}, 32'(ex_o.mem_write), 32'(exp.mem_write));
        check_val({"ex_o.branch_taken ", tag}, 32'(ex_o.branch_taken),
                  32'(exp.branch_taken));
        if (chk[0]) begin
            check_val({"ex_o.rd ", tag}, 32'(ex_o.rd), 32'(exp.rd));
            check_val({"ex_o.result ", tag}, ex_o.result, exp.result);
        end
        if (chk[1]) begin
            check_val({"ex_o.store_addr ", tag}, ex_o.store_addr, exp.store_addr);
            check_val({"ex_o.store_data ", tag}, ex_o.store_data, exp.store_data);
        end
        if (chk[2]) begin
            check_val({"ex_o.target ", tag}, ex_o.target, exp.target);
        end
    endtask

    initial begin
        int cycles;
        drive_vec('0);
        for (int k = 0; k < NUM_VEC*VEC_WORDS; k++) begin
            words[k] = ~32'(k); // never a legal flag value.
        end
        $readmemh("golden_vectors.txt", words);
        for (int i = 0; i < NUM_VEC; i++) begin
            // expected taken flag is the last single bit on a line.
            if (words[i*VEC_WORDS+16] > 32'd1) begin
                $display("vector file golden_vectors.txt is missing or too short");
                $display("** FAIL **");
                $fatal(1, "no vectors");
            end
            vecs[i] = unpack_vec(i * VEC_WORDS);
        end

        cycles = 0;
        while (rst_n_i !== 1'b1 && cycles < RST_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n_i !== 1'b1) begin
            $display("reset never completed within %0d cycles", RST_LIMIT);
            $display("** FAIL **");
            $fatal(1, "reset timeout");
        end
        compare_ex("(after reset)", '0, 4'h0); // register starts as a bubble.

        // drive on one falling edge and check on the next.
        for (int i = 0; i < NUM_VEC; i++) begin
            drive_vec(vecs[i]);
            @(negedge clk);
            compare_ex($sformatf("(vector %0d)", i), vecs[i].exp, vecs[i].chk);
        end

        $display("** PASS **");
        $finish;
    end

endmodule
